/* Makefile */
# Verilator build and run for the luma DC (Y2) path

VERILATOR ?= verilator
TOP       ?= tb_luma_dc
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@$(SIM) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dc_collector.sv */
//--------------------------------------------------------------------
// DC collector
// Gathers sixteen serial DC coefficients into a raster 4x4 block
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "vp8_settings.svh"

module dc_collector (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        mb_start_i,
    input  logic                        dc_valid_i,
    input  logic signed [`VP8_DC_W-1:0] dc_i,
    output vp8_dc_pkg::dc_block_t       block_o,
    output logic                        start_o
);
    import vp8_dc_pkg::*;

    localparam int CNT_W = $clog2(`VP8_NCOEF);

    dc_block_t        blk_q;
    logic [CNT_W-1:0] cnt_q;    // Next raster slot
    logic             start_q;
    logic             take;

    // New macroblock wins over a strobe in the same cycle
    assign take = dc_valid_i && !mb_start_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_q   <= '0;
            cnt_q   <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= take && (&cnt_q);   // Last slot filled
            if (mb_start_i) begin
                cnt_q <= '0;                // Partial block is dropped
            end else if (take) begin
                blk_q[cnt_q] <= dc_i;
                cnt_q        <= cnt_q + 1'b1;
            end
        end
    end

    assign block_o = blk_q;
    assign start_o = start_q;

    //----------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------
    // An X strobe would corrupt the count for the whole macroblock
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(dc_valid_i)
    ) else $error("dc_valid_i unknown out of reset");

endmodule

/* ftransform_wht.sv */
//--------------------------------------------------------------------
// Forward 4x4 Walsh-Hadamard transform of the luma DC block
// Row and column butterflies, halved output, one register stage
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "vp8_settings.svh"

module ftransform_wht (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  vp8_dc_pkg::dc_block_t  block_i,
    output vp8_dc_pkg::wht_block_t block_o,
    output logic                   done_o
);
    import vp8_dc_pkg::*;

    localparam int N     = `VP8_BLK;
    localparam int TMP_W = `VP8_DC_W + 2;   // Row pass adds two bits
    localparam int SUM_W = `VP8_WHT_W + 1;  // Column sums before halving

    logic signed [TMP_W-1:0] tmp [`VP8_NCOEF];
    wire wht_block_t         res_d;
    wht_block_t              block_q;
    logic                    done_q;

    //----------------------------------------------------------------
    // Row pass
    //----------------------------------------------------------------
    for (genvar r = 0; r < N; r++) begin : g_row
        logic signed [TMP_W-2:0] a0, a1, a2, a3;

        assign a0 = block_i[N*r + 0] + block_i[N*r + 2];
        assign a1 = block_i[N*r + 1] + block_i[N*r + 3];
        assign a2 = block_i[N*r + 1] - block_i[N*r + 3];
        assign a3 = block_i[N*r + 0] - block_i[N*r + 2];

        assign tmp[N*r + 0] = a0 + a1;
        assign tmp[N*r + 1] = a3 + a2;
        assign tmp[N*r + 2] = a3 - a2;
        assign tmp[N*r + 3] = a0 - a1;
    end

    //----------------------------------------------------------------
    // Column pass
    //----------------------------------------------------------------
    for (genvar c = 0; c < N; c++) begin : g_col
        logic signed [SUM_W-2:0] b0, b1, b2, b3;
        logic signed [SUM_W-1:0] y0, y1, y2, y3;

        assign b0 = tmp[c]     + tmp[2*N + c];
        assign b1 = tmp[N + c] + tmp[3*N + c];
        assign b2 = tmp[N + c] - tmp[3*N + c];
        assign b3 = tmp[c]     - tmp[2*N + c];

        assign y0 = b0 + b1;
        assign y1 = b3 + b2;
        assign y2 = b3 - b2;
        assign y3 = b0 - b1;

        // Dropping bit 0 of a signed sum halves it with floor
        assign res_d[c]       = y0[SUM_W-1:1];
        assign res_d[N + c]   = y1[SUM_W-1:1];
        assign res_d[2*N + c] = y2[SUM_W-1:1];
        assign res_d[3*N + c] = y3[SUM_W-1:1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_q <= '0;
            done_q  <= 1'b0;
        end else begin
            if (start_i) block_q <= res_d;   // Held until the next block
            done_q <= start_i;
        end
    end

    assign block_o = block_q;
    assign done_o  = done_q;

    // Start comes from the collector as a single pulse per block
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        start_i |=> done_o ##1 !done_o
    ) else $error("done_o is not a one-cycle pulse after start_i");

endmodule

/* luma_dc_top.sv */
//--------------------------------------------------------------------
// Luma DC (Y2) path top
// Collector, forward WHT and quantizer in a chain
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "vp8_settings.svh"

module luma_dc_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        mb_start_i,
    input  logic                        dc_valid_i,
    input  logic signed [`VP8_DC_W-1:0] dc_i,
    input  logic [`VP8_IQ_W-1:0]        q_iq_i,
    input  logic [`VP8_BIAS_W-1:0]      q_bias_i,
    output vp8_dc_pkg::y2_coef_t        coef_o,
    output logic                        coef_valid_o
);
    import vp8_dc_pkg::*;

    dc_block_t  dc_blk;
    logic       blk_start;
    wht_block_t wht_blk;
    logic       wht_done;

    dc_collector dc_collector_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .mb_start_i (mb_start_i),
        .dc_valid_i (dc_valid_i),
        .dc_i       (dc_i),
        .block_o    (dc_blk),
        .start_o    (blk_start)
    );

    ftransform_wht ftransform_wht_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (blk_start),
        .block_i (dc_blk),
        .block_o (wht_blk),
        .done_o  (wht_done)
    );

    // Config is sampled when the block loads
    y2_quantizer y2_quantizer_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (wht_done),
        .block_i      (wht_blk),
        .iq_i         (q_iq_i),
        .bias_i       (q_bias_i),
        .coef_o       (coef_o),
        .coef_valid_o (coef_valid_o)
    );

endmodule

/* src.f */
+incdir+.
vp8_dc_pkg.sv
dc_collector.sv
ftransform_wht.sv
y2_quantizer.sv
luma_dc_top.sv
tb_luma_dc.sv

/* tb_luma_dc.sv */
//----------------------------------------------------------------------
// Luma DC (Y2) path testbench
// LFSR stimulus, reference WHT and quantizer model, serial output check
//----------------------------------------------------------------------
`timescale 1ns/100ps
`include "vp8_settings.svh"

module tb_luma_dc;
    import vp8_dc_pkg::*;

    localparam int CLK_NS     = 4;
    localparam int NUM_BLOCKS = 42;     // Complete blocks plus dropped partial ones
    localparam int TIMEOUT_NS = (NUM_BLOCKS * 40 + 400) * CLK_NS;
    // 1 - 2^-17 with half a step of bias gives a gain of exactly one
    localparam logic [`VP8_IQ_W-1:0]   IQ_UNIT   = '1;
    localparam logic [`VP8_BIAS_W-1:0] BIAS_HALF = 17'h10000;

    logic                        clk;
    logic                        rst_n;
    logic                        mb_start_i;
    logic                        dc_valid_i;
    logic signed [`VP8_DC_W-1:0] dc_i;
    logic [`VP8_IQ_W-1:0]        q_iq_i;
    logic [`VP8_BIAS_W-1:0]      q_bias_i;
    y2_coef_t                    coef_o;
    logic                        coef_valid_o;

    logic [31:0] lfsr_q;
    y2_coef_t    exp_q [$];             // Expected words in output order
    bit          cont_q [$];            // Word must follow the previous one directly
    bit          chained;               // Block sent straight after the previous one
    int          dc_vals [`VP8_NCOEF];  // Raster order, as sent
    int          errors;

    luma_dc_top luma_dc_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .mb_start_i   (mb_start_i),
        .dc_valid_i   (dc_valid_i),
        .dc_i         (dc_i),
        .q_iq_i       (q_iq_i),
        .q_bias_i     (q_bias_i),
        .coef_o       (coef_o),
        .coef_valid_o (coef_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    //------------------------------------------------------------------
    // Stimulus source and reference model
    //------------------------------------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int quant_ref(input int x, input int iq, input int bias);
        longint mag;
        longint q;
        mag = (x < 0) ? -x : x;
        q   = (mag * iq + bias) >>> `VP8_QFIX;
        if (q > 2047) q = 2047;
        return (x < 0) ? -int'(q) : int'(q);
    endfunction

    task automatic compute_expected(input logic [`VP8_IQ_W-1:0] iq,
                                    input logic [`VP8_BIAS_W-1:0] bias);
        int       tmp [16];
        int       y [16];
        int       a0, a1, a2, a3;
        int       lvl;
        y2_coef_t e;
        for (int r = 0; r < 4; r++) begin   // Row pass
            a0 = dc_vals[4*r] + dc_vals[4*r + 2];
            a1 = dc_vals[4*r + 1] + dc_vals[4*r + 3];
            a2 = dc_vals[4*r + 1] - dc_vals[4*r + 3];
            a3 = dc_vals[4*r] - dc_vals[4*r + 2];
            tmp[4*r]     = a0 + a1;
            tmp[4*r + 1] = a3 + a2;
            tmp[4*r + 2] = a3 - a2;
            tmp[4*r + 3] = a0 - a1;
        end
        for (int c = 0; c < 4; c++) begin   // Column pass, halved
            a0 = tmp[c] + tmp[8 + c];
            a1 = tmp[4 + c] + tmp[12 + c];
            a2 = tmp[4 + c] - tmp[12 + c];
            a3 = tmp[c] - tmp[8 + c];
            y[c]      = (a0 + a1) >>> 1;
            y[4 + c]  = (a3 + a2) >>> 1;
            y[8 + c]  = (a3 - a2) >>> 1;
            y[12 + c] = (a0 - a1) >>> 1;
        end
        for (int p = 0; p < 16; p++) begin
            lvl     = quant_ref(y[ZIGZAG[p]], int'(iq), int'(bias));
            e.level = lvl[`VP8_LEVEL_W-1:0];
            e.pos   = 4'(p);
            e.last  = (p == 15);
            exp_q.push_back(e);
            cont_q.push_back(p > 0 || chained);
        end
    endtask

    // Config changes on strobe 3, after the previous block has loaded
    task automatic send_block(input bit gaps, input logic [`VP8_IQ_W-1:0] iq,
                              input logic [`VP8_BIAS_W-1:0] bias, input int shift);
        logic [31:0]                 r;
        logic signed [`VP8_DC_W-1:0] v;
        for (int i = 0; i < 16; i++) begin
            if (gaps && rand_bits(2) == 0) begin
                @(negedge clk);
                dc_valid_i = 1'b0;
                dc_i       = 12'h5a5;       // Ignored without a strobe
            end
            r = rand_bits(`VP8_DC_W);
            v = $signed(r[`VP8_DC_W-1:0]) >>> shift;
            @(negedge clk);
            if (i == 3) begin
                q_iq_i   = iq;
                q_bias_i = bias;
            end
            dc_valid_i = 1'b1;
            dc_i       = v;
            dc_vals[i] = int'(v);
        end
        compute_expected(iq, bias);
    endtask

    // Partial block, then a new macroblock with a colliding strobe
    task automatic abort_block(input int n);
        logic [31:0] r;
        for (int i = 0; i <= n; i++) begin
            r = rand_bits(`VP8_DC_W);
            @(negedge clk);
            mb_start_i = (i == n);
            dc_valid_i = 1'b1;
            dc_i       = r[`VP8_DC_W-1:0];
        end
        @(negedge clk);
        mb_start_i = 1'b0;
        dc_valid_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            dc_valid_i = 1'b0;
        end
    endtask

    //------------------------------------------------------------------
    // Output monitor
    //------------------------------------------------------------------
    initial begin
        y2_coef_t e;
        bit       cont;
        logic     prev_valid;
        prev_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && coef_valid_o) begin
                assert (exp_q.size() > 0) else begin
                    $display("Error at %0t: output word pos %0d with no block expected",
                             $time, coef_o.pos);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    e    = exp_q.pop_front();
                    cont = cont_q.pop_front();
                    assert (prev_valid || !cont) else begin
                        $display("Error at %0t: coef_valid_o dropped before pos %0d",
                                 $time, e.pos);
                        errors++;
                    end
                    assert (coef_o.level == e.level) else begin
                        $display("Mismatch at %0t: coef_o.level expected %0d got %0d",
                                 $time, e.level, coef_o.level);
                        errors++;
                    end
                    assert (coef_o.pos == e.pos) else begin
                        $display("Mismatch at %0t: coef_o.pos expected %0d got %0d",
                                 $time, e.pos, coef_o.pos);
                        errors++;
                    end
                    assert (coef_o.last == e.last) else begin
                        $display("Mismatch at %0t: coef_o.last expected %0b got %0b",
                                 $time, e.last, coef_o.last);
                        errors++;
                    end
                end
            end
            prev_valid = rst_n && coef_valid_o;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [`VP8_IQ_W-1:0]   iq;
        logic [`VP8_BIAS_W-1:0] bias;
        int                     n;
        errors     = 0;
        chained    = 1'b0;
        lfsr_q     = 32'hf93b_9ee3;
        rst_n      = 1'b0;
        mb_start_i = 1'b0;
        dc_valid_i = 1'b0;
        dc_i       = '0;
        q_iq_i     = IQ_UNIT;
        q_bias_i   = BIAS_HALF;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (20) begin                   // Quiet output before any input
            @(negedge clk);
            assert (!coef_valid_o) else begin
                $display("Error at %0t: coef_valid_o high before any input", $time);
                errors++;
            end
        end

        repeat (6) begin                    // Unit gain, full range
            send_block(1'b0, IQ_UNIT, BIAS_HALF, 0);
            idle_cycles(3);
        end
        repeat (12) begin                   // Random step and bias, scaled inputs
            iq   = rand_bits(`VP8_IQ_W);
            bias = rand_bits(`VP8_BIAS_W);
            n    = rand_bits(3);
            send_block(1'b1, iq, bias, n);
            idle_cycles(2);
        end
        repeat (8) begin                    // Gaps, no idle between blocks
            iq   = rand_bits(`VP8_IQ_W);
            bias = rand_bits(`VP8_BIAS_W);
            send_block(1'b1, iq, bias, 0);
        end
        chained = 1'b1;
        repeat (8) begin                    // Strictly back to back
            iq   = rand_bits(`VP8_IQ_W);
            bias = rand_bits(`VP8_BIAS_W);
            send_block(1'b0, iq, bias, 0);
        end
        chained = 1'b0;
        idle_cycles(1);
        repeat (4) begin                    // Dropped partial blocks
            n = 1 + int'(rand_bits(4) % 15);
            abort_block(n);
            iq   = rand_bits(`VP8_IQ_W);
            bias = rand_bits(`VP8_BIAS_W);
            send_block(1'b1, iq, bias, 0);
            idle_cycles(2);
        end

        for (int i = 0; i < 100 && exp_q.size() > 0; i++) @(negedge clk);
        idle_cycles(10);
        assert (exp_q.size() == 0) else begin
            $display("Error: %0d expected output words never appeared", exp_q.size());
            errors++;
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vp8_dc_pkg.sv */
//--------------------------------------------------------------------
// Luma DC path types
// Raster blocks, the Y2 output word and the zigzag scan table
//--------------------------------------------------------------------
`include "vp8_settings.svh"

package vp8_dc_pkg;

    // Single coefficients, signed so element selects stay signed
    typedef logic signed [`VP8_DC_W-1:0]  dc_coef_t;
    typedef logic signed [`VP8_WHT_W-1:0] wht_coef_t;

    // Index is row * 4 + column
    typedef dc_coef_t  [`VP8_NCOEF-1:0] dc_block_t;    // 192 bits
    typedef wht_coef_t [`VP8_NCOEF-1:0] wht_block_t;   // 240 bits

    // One quantized Y2 level on the output
    typedef struct packed {
        logic signed [`VP8_LEVEL_W-1:0] level;
        logic [3:0]                     pos;    // Zigzag position
        logic                           last;   // Set on position 15
    } y2_coef_t;

    //----------------------------------------------------------------
    // VP8 zigzag scan, position to raster index
    //----------------------------------------------------------------
    localparam logic [3:0] ZIGZAG [`VP8_NCOEF] = '{
        4'd0,  4'd1,  4'd4,  4'd8,
        4'd5,  4'd2,  4'd3,  4'd6,
        4'd9,  4'd12, 4'd13, 4'd10,
        4'd7,  4'd11, 4'd14, 4'd15
    };

endpackage

/* vp8_settings.svh */
//--------------------------------------------------------------------
// Luma DC (Y2) path settings
// Coefficient widths, block geometry and quantizer fixed point
//--------------------------------------------------------------------
`ifndef VP8_SETTINGS_SVH
`define VP8_SETTINGS_SVH

// Block geometry
`define VP8_BLK     4       // Block is VP8_BLK x VP8_BLK
`define VP8_NCOEF   16      // Coefficients per block

// Coefficient widths, all signed
`define VP8_DC_W    12      // DC input from the DCT
`define VP8_WHT_W   15      // After the halved WHT
`define VP8_LEVEL_W 12      // Quantized level, saturates at +/-2047

//--------------------------------------------------------------------
// Quantizer fixed point
//--------------------------------------------------------------------
// Level magnitude is (|x| * iq + bias) >> QFIX
`define VP8_IQ_W    17      // Reciprocal step
`define VP8_BIAS_W  17      // Rounding bias
`define VP8_QFIX    17

`endif

/* y2_quantizer.sv */
//--------------------------------------------------------------------
// Y2 quantizer
// Emits sixteen quantized levels per block in zigzag order
//--------------------------------------------------------------------
`timescale 1ns/100ps
`include "vp8_settings.svh"

module y2_quantizer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_i,
    input  vp8_dc_pkg::wht_block_t  block_i,
    input  logic [`VP8_IQ_W-1:0]    iq_i,
    input  logic [`VP8_BIAS_W-1:0]  bias_i,
    output vp8_dc_pkg::y2_coef_t    coef_o,
    output logic                    coef_valid_o
);
    import vp8_dc_pkg::*;

    localparam int WHT_W   = `VP8_WHT_W;
    localparam int IQ_W    = `VP8_IQ_W;
    localparam int BIAS_W  = `VP8_BIAS_W;
    localparam int LVL_W   = `VP8_LEVEL_W;
    localparam int QFIX    = `VP8_QFIX;
    localparam int ACC_W   = WHT_W + IQ_W + 1;     // Product plus bias
    localparam int LVL_MAX = 2**(LVL_W-1) - 1;     // 2047

    // sign(x) * min((|x| * iq + bias) >> QFIX, LVL_MAX)
    function automatic logic signed [LVL_W-1:0] quant(
        input logic signed [WHT_W-1:0] x,
        input logic [IQ_W-1:0]         iq,
        input logic [BIAS_W-1:0]       bias
    );
        logic [WHT_W-1:0]      mag;
        logic [ACC_W-1:0]      acc;
        logic [ACC_W-QFIX-1:0] q;
        logic [LVL_W-1:0]      sat;
        mag   = x[WHT_W-1] ? -x : x;     // -16384 still fits unsigned
        acc   = mag * iq + bias;
        q     = acc[ACC_W-1:QFIX];
        sat   = (q > LVL_MAX) ? LVL_W'(LVL_MAX) : q[LVL_W-1:0];
        quant = x[WHT_W-1] ? -$signed(sat) : $signed(sat);
    endfunction

    wht_block_t        blk_q;
    logic [IQ_W-1:0]   iq_q;
    logic [BIAS_W-1:0] bias_q;
    logic [3:0]        pos_q;       // Next zigzag position
    logic              busy_q;
    y2_coef_t          coef_q;
    logic              valid_q;

    wht_block_t        sel_blk;
    logic [IQ_W-1:0]   sel_iq;
    logic [BIAS_W-1:0] sel_bias;
    logic [3:0]        sel_pos;
    y2_coef_t          coef_d;

    //----------------------------------------------------------------
    // Position 0 comes straight from the inputs on a load
    //----------------------------------------------------------------
    always_comb begin
        sel_blk      = load_i ? block_i : blk_q;
        sel_iq       = load_i ? iq_i    : iq_q;
        sel_bias     = load_i ? bias_i  : bias_q;
        sel_pos      = load_i ? 4'd0    : pos_q;
        coef_d.level = quant(sel_blk[ZIGZAG[sel_pos]], sel_iq, sel_bias);
        coef_d.pos   = sel_pos;
        coef_d.last  = &sel_pos;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_q   <= '0;
            iq_q    <= '0;
            bias_q  <= '0;
            pos_q   <= '0;
            busy_q  <= 1'b0;
            coef_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_i || busy_q;
            if (load_i || busy_q) coef_q <= coef_d;
            if (load_i) begin
                blk_q  <= block_i;
                iq_q   <= iq_i;
                bias_q <= bias_i;
                pos_q  <= 4'd1;
                busy_q <= 1'b1;
            end else if (busy_q) begin
                pos_q  <= pos_q + 1'b1;
                busy_q <= ~&pos_q;          // Idle once 15 is out
            end
        end
    end

    assign coef_o       = coef_q;
    assign coef_valid_o = valid_q;

    // A new block may only land while position 15 is on the output
    a_load_gap: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_i |-> (!coef_valid_o || coef_o.last)
    ) else $error("load_i while a block is still being emitted");

endmodule
